// ==== source/sap_pkg.sv ====
`default_nettype none

package sap_pkg;

    // Instruction byte is {opcode, address}, so these widths are tied together
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 4;
    localparam int OPC_W     = 4;
    localparam int MEM_DEPTH = 16;

    // Opcodes in the upper half of an instruction byte
    typedef enum logic [OPC_W-1:0] {
        // Load A from memory
        OP_LDA = 4'b1000,
        // Load B from memory
        OP_LDB = 4'b0100,
        // Accumulator gets A + B
        OP_ADD = 4'b0010,
        // Accumulator gets A - B
        OP_SUB = 4'b0001,
        // Program counter gets the address field
        OP_JMP = 4'b1001,
        // Stop until reset
        OP_HLT = 4'b1111,
        // Store accumulator at the address field
        OP_WRT = 4'b1010,
        // Put A on the data output
        OP_DMA = 4'b1011,
        // Put B on the data output
        OP_DMB = 4'b1101
    } opcode_t;

    // Instruction cycle, four states per instruction plus halt
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_OPERAND,
        S_EXECUTE,
        S_HALT
    } seq_state_t;

    // Adder/subtractor select
    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_t;

endpackage

`default_nettype wire

// ==== source/unified_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module unified_ram (
    input  logic                       clk,
    // Program side read port
    input  logic [sap_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic [sap_pkg::DATA_W-1:0] fetch_data_o,
    // Operand side read port and store address
    input  logic [sap_pkg::ADDR_W-1:0] oper_addr_i,
    output logic [sap_pkg::DATA_W-1:0] oper_data_o,
    // Accumulator store
    input  logic                       store_i,
    input  logic [sap_pkg::DATA_W-1:0] store_data_i,
    // External program load
    input  logic                       load_en_i,
    input  logic [sap_pkg::ADDR_W-1:0] load_addr_i,
    input  logic [sap_pkg::DATA_W-1:0] load_data_i
);
    import sap_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    // Single write port with the external load taking priority over a store
    always_comb begin
        wr_en   = load_en_i | store_i;
        wr_addr = oper_addr_i;
        wr_data = store_data_i;
        if (load_en_i) begin
            wr_addr = load_addr_i;
            wr_data = load_data_i;
        end
    end

    // Memory write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Both read ports registered and read every cycle
    always_ff @(posedge clk) begin
        fetch_data_o <= mem[fetch_addr_i];
        oper_data_o  <= mem[oper_addr_i];
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       reset,
    // Strobes from the sequencer
    input  logic                       ir_load_i,
    input  logic                       jump_i,
    // Byte read at the program counter
    input  logic [sap_pkg::DATA_W-1:0] fetch_data_i,
    output logic [sap_pkg::ADDR_W-1:0] pc_o,
    output sap_pkg::opcode_t           opcode_o,
    output logic [sap_pkg::ADDR_W-1:0] operand_addr_o
);
    import sap_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] ir;

    // Program counter
    // Increments past the instruction being captured, jump overwrites it
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (jump_i) begin
            pc <= operand_addr_o;
        end else if (ir_load_i) begin
            // Wraps from 15 back to 0
            pc <= pc + ADDR_W'(1);
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load_i) begin
            ir <= fetch_data_i;
        end
    end

    assign pc_o = pc;

    // Upper half is the opcode, lower half the address
    assign opcode_o       = opcode_t'(ir[DATA_W-1 -: OPC_W]);
    assign operand_addr_o = ir[ADDR_W-1:0];

endmodule

`default_nettype wire

// ==== source/data_path.sv ====
`default_nettype none
`timescale 1ns/1ps

module data_path (
    input  logic                       clk,
    input  logic                       reset,
    // Strobes from the sequencer
    input  logic                       load_a_i,
    input  logic                       load_b_i,
    input  logic                       alu_strobe_i,
    input  logic                       dump_a_i,
    input  logic                       dump_b_i,
    input  sap_pkg::alu_op_t           alu_op_i,
    // Byte read at the operand address
    input  logic [sap_pkg::DATA_W-1:0] operand_i,
    output logic [sap_pkg::DATA_W-1:0] acc_o,
    output logic [sap_pkg::DATA_W-1:0] data_o,
    output logic                       out_valid_o
);
    import sap_pkg::*;

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] alu_result;

    // Operand registers
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= '0;
            reg_b <= '0;
        end else begin
            if (load_a_i) begin
                reg_a <= operand_i;
            end
            if (load_b_i) begin
                reg_b <= operand_i;
            end
        end
    end

    // Sum or difference, both modulo 256
    always_comb begin
        if (alu_op_i == ALU_SUB) begin
            alu_result = reg_a - reg_b;
        end else begin
            alu_result = reg_a + reg_b;
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (alu_strobe_i) begin
            acc <= alu_result;
        end
    end

    assign acc_o = acc;

    // Output register, valid for the one cycle after a dump
    always_ff @(posedge clk) begin
        if (reset) begin
            data_o      <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= dump_a_i | dump_b_i;
            if (dump_a_i) begin
                data_o <= reg_a;
            end else if (dump_b_i) begin
                data_o <= reg_b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/control_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module control_sequencer (
    input  logic             clk,
    input  logic             reset,
    // Opcode held in the instruction register
    input  sap_pkg::opcode_t opcode_i,
    // Program side strobes
    output logic             ir_load_o,
    output logic             jump_o,
    // Operand side strobes
    output logic             load_a_o,
    output logic             load_b_o,
    output logic             alu_strobe_o,
    output sap_pkg::alu_op_t alu_op_o,
    output logic             store_o,
    output logic             dump_a_o,
    output logic             dump_b_o,
    output logic             halted_o
);
    import sap_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // Fixed four-step cycle, halt is sticky until reset
    always_comb begin
        state_next = state;
        case (state)
            S_FETCH: begin
                state_next = S_DECODE;
            end
            S_DECODE: begin
                state_next = S_OPERAND;
            end
            S_OPERAND: begin
                state_next = S_EXECUTE;
            end
            S_EXECUTE: begin
                if (opcode_i == OP_HLT) begin
                    state_next = S_HALT;
                end else begin
                    state_next = S_FETCH;
                end
            end
            S_HALT: begin
                state_next = S_HALT;
            end
            default: begin
                state_next = S_FETCH;
            end
        endcase
    end

    // IR captures the fetched byte at the end of decode
    assign ir_load_o = (state == S_DECODE);

    // One strobe per instruction, only in execute
    always_comb begin
        jump_o       = 1'b0;
        load_a_o     = 1'b0;
        load_b_o     = 1'b0;
        alu_strobe_o = 1'b0;
        store_o      = 1'b0;
        dump_a_o     = 1'b0;
        dump_b_o     = 1'b0;
        if (state == S_EXECUTE) begin
            case (opcode_i)
                OP_LDA:  load_a_o     = 1'b1;
                OP_LDB:  load_b_o     = 1'b1;
                OP_ADD:  alu_strobe_o = 1'b1;
                OP_SUB:  alu_strobe_o = 1'b1;
                OP_JMP:  jump_o       = 1'b1;
                OP_WRT:  store_o      = 1'b1;
                OP_DMA:  dump_a_o     = 1'b1;
                OP_DMB:  dump_b_o     = 1'b1;
                // HLT and unknown opcodes issue nothing
                default: ;
            endcase
        end
    end

    // Only matters alongside alu_strobe_o
    assign alu_op_o = (opcode_i == OP_SUB) ? ALU_SUB : ALU_ADD;

    assign halted_o = (state == S_HALT);

endmodule

`default_nettype wire

// ==== source/sap_cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module sap_cpu (
    input  logic                       clk,
    input  logic                       reset,
    // Program load, used while reset is held
    input  logic                       load_en_i,
    input  logic [sap_pkg::ADDR_W-1:0] load_addr_i,
    input  logic [sap_pkg::DATA_W-1:0] load_data_i,
    // Observation outputs
    output logic [sap_pkg::ADDR_W-1:0] pc_o,
    output logic [sap_pkg::DATA_W-1:0] data_o,
    output logic                       out_valid_o,
    output logic                       halted_o
);

    // Program side
    logic [sap_pkg::DATA_W-1:0] fetch_data;
    logic [sap_pkg::ADDR_W-1:0] operand_addr;
    sap_pkg::opcode_t           opcode;
    logic                       ir_load;
    logic                       jump;

    // Operand side
    logic [sap_pkg::DATA_W-1:0] oper_data;
    logic [sap_pkg::DATA_W-1:0] acc;
    sap_pkg::alu_op_t           alu_op;
    logic                       load_a;
    logic                       load_b;
    logic                       alu_strobe;
    logic                       store;
    logic                       dump_a;
    logic                       dump_b;

    unified_ram u_ram (
        .clk          (clk),
        .fetch_addr_i (pc_o),
        .fetch_data_o (fetch_data),
        .oper_addr_i  (operand_addr),
        .oper_data_o  (oper_data),
        .store_i      (store),
        .store_data_i (acc),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i)
    );

    fetch_unit u_fetch (
        .clk            (clk),
        .reset          (reset),
        .ir_load_i      (ir_load),
        .jump_i         (jump),
        .fetch_data_i   (fetch_data),
        .pc_o           (pc_o),
        .opcode_o       (opcode),
        .operand_addr_o (operand_addr)
    );

    data_path u_data (
        .clk          (clk),
        .reset        (reset),
        .load_a_i     (load_a),
        .load_b_i     (load_b),
        .alu_strobe_i (alu_strobe),
        .dump_a_i     (dump_a),
        .dump_b_i     (dump_b),
        .alu_op_i     (alu_op),
        .operand_i    (oper_data),
        .acc_o        (acc),
        .data_o       (data_o),
        .out_valid_o  (out_valid_o)
    );

    control_sequencer u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .opcode_i     (opcode),
        .ir_load_o    (ir_load),
        .jump_o       (jump),
        .load_a_o     (load_a),
        .load_b_o     (load_b),
        .alu_strobe_o (alu_strobe),
        .alu_op_o     (alu_op),
        .store_o      (store),
        .dump_a_o     (dump_a),
        .dump_b_o     (dump_b),
        .halted_o     (halted_o)
    );

endmodule

`default_nettype wire

// ==== dv/sap_cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module sap_cpu_tb;
    import sap_pkg::*;

    // Model step limit and the matching wait limit for halted_o
    localparam int MODEL_LIMIT  = 64;
    localparam int HALT_TIMEOUT = 4 * MODEL_LIMIT + 16;
    localparam int RESET_CYCLES = 10;

    logic              clk;
    logic              reset;
    logic              load_en_i;
    logic [ADDR_W-1:0] load_addr_i;
    logic [DATA_W-1:0] load_data_i;
    logic [ADDR_W-1:0] pc_o;
    logic [DATA_W-1:0] data_o;
    logic              out_valid_o;
    logic              halted_o;

    // Memory image of the program under test
    logic [DATA_W-1:0] mem_img [MEM_DEPTH];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] got_q [$];

    int seed = 32'hd39a_69b7;
    int mismatches = 0;
    int timeouts = 0;

    sap_cpu DUT (
        .clk         (clk),
        .reset       (reset),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .pc_o        (pc_o),
        .data_o      (data_o),
        .out_valid_o (out_valid_o),
        .halted_o    (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        mismatches++;
        $display("MISMATCH at %0t ns: %s expected 0x%0h actual 0x%0h",
                 $time, sig, exp_val, act_val);
    endtask

    // Output pulses are one cycle wide
    pulse_width_a: assert property (@(posedge clk) disable iff (reset)
        out_valid_o |=> !out_valid_o)
        else report_mismatch("out_valid_o", 32'd0, 32'd1);

    // Halt holds until reset
    halt_sticky_a: assert property (@(posedge clk) disable iff (reset)
        halted_o |=> halted_o)
        else report_mismatch("halted_o", 32'd1, 32'd0);

    halt_quiet_a: assert property (@(posedge clk) disable iff (reset)
        halted_o |-> !out_valid_o)
        else report_mismatch("out_valid_o", 32'd0, 32'd1);

    halt_pc_a: assert property (@(posedge clk) disable iff (reset)
        halted_o |=> $stable(pc_o))
        else report_mismatch("pc_o", 32'($past(pc_o)), 32'(pc_o));

    // Collect every dumped byte
    always @(negedge clk) begin
        if (!reset && out_valid_o) begin
            got_q.push_back(data_o);
        end
    end

    function automatic logic [DATA_W-1:0] encode(input opcode_t op,
                                                 input logic [ADDR_W-1:0] addr);
        return {op, addr};
    endfunction

    task automatic fill_random();
        logic [31:0] rnd;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            rnd = $random(seed);
            mem_img[i] = rnd[DATA_W-1:0];
        end
    endtask

    // Reference model of the instruction set, fills exp_q
    task automatic run_model(output int n_exec);
        logic [DATA_W-1:0] m [MEM_DEPTH];
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] acc;
        opcode_t           op;
        bit                stop;
        m = mem_img;
        pc = '0;
        a = '0;
        b = '0;
        acc = '0;
        stop = 1'b0;
        n_exec = 0;
        exp_q.delete();
        while (!stop && n_exec < MODEL_LIMIT) begin
            op = opcode_t'(m[pc][DATA_W-1 -: OPC_W]);
            addr = m[pc][ADDR_W-1:0];
            pc = pc + 4'd1;
            n_exec++;
            case (op)
                OP_LDA: a = m[addr];
                OP_LDB: b = m[addr];
                OP_ADD: acc = a + b;
                OP_SUB: acc = a - b;
                OP_WRT: m[addr] = acc;
                OP_JMP: pc = addr;
                OP_DMA: exp_q.push_back(a);
                OP_DMB: exp_q.push_back(b);
                OP_HLT: stop = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic check_reset_outputs();
        assert (out_valid_o == 1'b0) else report_mismatch("out_valid_o", 32'd0, 32'(out_valid_o));
        assert (halted_o == 1'b0) else report_mismatch("halted_o", 32'd0, 32'(halted_o));
        assert (pc_o == '0) else report_mismatch("pc_o", 32'd0, 32'(pc_o));
        assert (data_o == '0) else report_mismatch("data_o", 32'd0, 32'(data_o));
    endtask

    // Hold reset, load all 16 bytes, then release reset
    task automatic load_under_reset();
        @(posedge clk);
        reset <= 1'b1;
        load_en_i <= 1'b0;
        got_q.delete();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            load_en_i <= 1'b1;
            load_addr_i <= ADDR_W'(i);
            load_data_i <= mem_img[i];
        end
        @(posedge clk);
        load_en_i <= 1'b0;
        reset <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int n_exec;
        int cycles;
        run_model(n_exec);
        $display("Running %s, %0d instructions to halt", name, n_exec);
        load_under_reset();
        @(negedge clk);
        check_reset_outputs();
        cycles = 0;
        while (!halted_o && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (cycles == 1) begin
                check_reset_outputs();
            end
        end
        if (!halted_o) begin
            timeouts++;
            $display("Timeout at %0t ns: halted_o never rose during %s", $time, name);
        end else begin
            assert (cycles == 4 * n_exec)
                else report_mismatch("halted_o rise cycle", 32'(4 * n_exec), 32'(cycles));
        end
        // Observation window after halt
        repeat (8) @(negedge clk);
        assert (got_q.size() == exp_q.size())
            else report_mismatch("out_valid_o pulse count", 32'(exp_q.size()), 32'(got_q.size()));
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
                else report_mismatch("data_o", 32'(exp_q[i]), 32'(got_q[i]));
        end
    endtask

    task automatic build_load_dump();
        fill_random();
        mem_img[0] = encode(OP_LDA, 4'd14);
        mem_img[1] = encode(OP_LDB, 4'd15);
        mem_img[2] = encode(OP_DMA, 4'd0);
        mem_img[3] = encode(OP_DMB, 4'd0);
        mem_img[4] = encode(OP_HLT, 4'd0);
    endtask

    // Sum and difference both go through memory before the dump
    task automatic build_arith(input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y);
        fill_random();
        mem_img[0]  = encode(OP_LDA, 4'd13);
        mem_img[1]  = encode(OP_LDB, 4'd14);
        mem_img[2]  = encode(OP_ADD, 4'd0);
        mem_img[3]  = encode(OP_WRT, 4'd15);
        mem_img[4]  = encode(OP_LDA, 4'd15);
        mem_img[5]  = encode(OP_DMA, 4'd0);
        mem_img[6]  = encode(OP_LDA, 4'd13);
        mem_img[7]  = encode(OP_SUB, 4'd0);
        mem_img[8]  = encode(OP_WRT, 4'd15);
        mem_img[9]  = encode(OP_LDA, 4'd15);
        mem_img[10] = encode(OP_DMA, 4'd0);
        mem_img[11] = encode(OP_HLT, 4'd0);
        mem_img[13] = x;
        mem_img[14] = y;
    endtask

    // JMP skips two DMB bytes, B differs from A so a stray pulse shows
    task automatic build_jump();
        fill_random();
        mem_img[0]  = encode(OP_LDA, 4'd14);
        mem_img[1]  = encode(OP_LDB, 4'd15);
        mem_img[2]  = encode(OP_JMP, 4'd5);
        mem_img[3]  = encode(OP_DMB, 4'd0);
        mem_img[4]  = encode(OP_DMB, 4'd0);
        mem_img[5]  = encode(OP_DMA, 4'd0);
        mem_img[6]  = encode(OP_HLT, 4'd0);
        mem_img[15] = mem_img[14] ^ 8'h5a;
    endtask

    initial begin
        logic [31:0] rnd;
        reset = 1'b1;
        load_en_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;

        build_load_dump();
        run_program("load and dump");

        rnd = $random(seed);
        build_arith(rnd[7:0], rnd[15:8]);
        run_program("add and subtract");

        // Both results wrap modulo 256
        build_arith(8'hc8, 8'he0);
        run_program("wraparound");

        build_jump();
        run_program("jump");

        $display("Done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sap_cpu.f ====
source/sap_pkg.sv
source/unified_ram.sv
source/fetch_unit.sv
source/data_path.sv
source/control_sequencer.sv
source/sap_cpu.sv
dv/sap_cpu_tb.sv

// ==== Makefile ====
TOP := sap_cpu_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sap_cpu.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
